// File: include/host_macros.svh
`ifndef HOST_MACROS_SVH
`define HOST_MACROS_SVH

// Address window codes in wbs_adr_i[31:28] and [27:24]
`define CH_USER_SPACE 4'h3
`define CH_HOST_PERIPH 4'hF

// Peripheral ID in peripheral address bits 23:16
`define CH_UART_ID 8'h01

// UART register byte offsets in the local address
`define CH_UART_TX_REG 16'h0000
`define CH_UART_RX_REG 16'h0004
`define CH_UART_STATUS_REG 16'h0008

// Kept small so that simulation stays short
`define CH_CLKS_PER_BIT 8

`endif

// File: src/host_pkg.sv
`default_nettype none

package host_pkg;

	// Peripheral ID and register offset inside the selected device
	typedef struct packed {
		logic [7:0]  id;
		logic [15:0] local_addr;
	} periph_fields_t;

	// Bridge drives the raw word, devices decode the fields
	typedef union packed {
		logic [23:0]    raw;
		periph_fields_t fields;
	} periph_addr_u;

	// Low 3 bits of the UART status register
	typedef struct packed {
		logic rx_valid;
		logic rx_overrun;
		logic tx_busy;
	} uart_status_t;

endpackage

`default_nettype wire

// File: src/periph_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;

	logic                      we;
	logic                      oe;
	logic                      busy;
	host_pkg::periph_addr_u    address;
	logic [3:0]                byte_select;
	logic [31:0]               data_write;
	logic [31:0]               data_read;

	// Bridge side issues the access
	modport bridge (
		output we, oe, address, byte_select, data_write,
		input  busy, data_read
	);

	// Device side answers and may stall
	modport device (
		input  we, oe, address, byte_select, data_write,
		output busy, data_read
	);

endinterface

`default_nettype wire

// File: src/wb_periph_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_periph_bridge (
	input  wire        wb_clk_i,
	input  wire        reset_i,
	input  wire        wb_stb_i,
	input  wire        wb_cyc_i,
	input  wire        wb_we_i,
	input  wire [3:0]  wb_sel_i,
	input  wire [31:0] wb_data_i,
	input  wire [23:0] wb_adr_i,
	output logic       wb_ack_o,
	output logic [31:0] wb_data_o,
	periph_bus_if.bridge pbus
);

	logic pending;
	logic access;
	logic done;

	// One access per Wishbone cycle, blocked once it has completed
	assign access = wb_stb_i && wb_cyc_i && !pending;
	assign done = access && !pbus.busy;

	assign pbus.we = access && wb_we_i;
	assign pbus.oe = access && !wb_we_i;
	assign pbus.address.raw = wb_adr_i;
	assign pbus.byte_select = wb_sel_i;
	assign pbus.data_write = wb_data_i;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			wb_ack_o <= 1'b0;
			pending <= 1'b0;
		end else begin
			wb_ack_o <= done;
			if (done) begin
				pending <= 1'b1;
			end else if (!(wb_stb_i && wb_cyc_i)) begin
				// Master has dropped the strobe after ack
				pending <= 1'b0;
			end
		end
	end

	// Read data is captured in the completing cycle
	always_ff @(posedge wb_clk_i) begin
		if (done && !wb_we_i) begin
			wb_data_o <= pbus.data_read;
		end
	end

endmodule

`default_nettype wire

// File: src/uart_device.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_macros.svh"

module uart_device (
	input  wire  wb_clk_i,
	input  wire  reset_i,
	input  wire  uart_rx_i,
	output logic uart_tx_o,
	periph_bus_if.device pbus
);

	localparam int CNT_W = $clog2(`CH_CLKS_PER_BIT) + 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`CH_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(`CH_CLKS_PER_BIT / 2);

	logic                   dev_sel;
	logic [15:0]            local_addr;
	logic                   tx_write;
	logic                   rx_read;
	host_pkg::uart_status_t status;

	logic [9:0]       tx_shift;
	logic [CNT_W-1:0] tx_cnt;
	logic [3:0]       tx_bit;
	logic             tx_busy;

	logic             rx_meta;
	logic             rx_sync;
	logic             rx_active;
	logic [CNT_W-1:0] rx_cnt;
	logic [3:0]       rx_bit;
	logic [7:0]       rx_shift;
	logic [7:0]       rx_data;
	logic             rx_valid;
	logic             rx_overrun;

	assign dev_sel = pbus.address.fields.id == `CH_UART_ID;
	assign local_addr = pbus.address.fields.local_addr;

	assign tx_write = dev_sel && pbus.we && local_addr == `CH_UART_TX_REG && pbus.byte_select[0];
	assign rx_read = dev_sel && pbus.oe && local_addr == `CH_UART_RX_REG;

	// Stall a TX write until the frame on the line has ended
	assign pbus.busy = tx_write && tx_busy;

	assign status.rx_valid = rx_valid;
	assign status.rx_overrun = rx_overrun;
	assign status.tx_busy = tx_busy;

	always_comb begin
		pbus.data_read = 32'h0;
		if (dev_sel) begin
			case (local_addr)
				`CH_UART_RX_REG:     pbus.data_read[7:0] = rx_data;
				`CH_UART_STATUS_REG: pbus.data_read[2:0] = status;
				default:             pbus.data_read = 32'h0;
			endcase
		end
	end

	assign uart_tx_o = tx_busy ? tx_shift[0] : 1'b1;

	// Transmitter, stop bit and start bit framed around the byte
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			tx_busy <= 1'b0;
		end else if (tx_write && !tx_busy) begin
			tx_shift <= {1'b1, pbus.data_write[7:0], 1'b0};
			tx_cnt <= '0;
			tx_bit <= '0;
			tx_busy <= 1'b1;
		end else if (tx_busy) begin
			if (tx_cnt == LAST_CNT) begin
				tx_cnt <= '0;
				tx_shift <= {1'b1, tx_shift[9:1]};
				if (tx_bit == 4'd9) begin
					tx_busy <= 1'b0;
				end else begin
					tx_bit <= tx_bit + 4'd1;
				end
			end else begin
				tx_cnt <= tx_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx_i;
			rx_sync <= rx_meta;
		end
	end

	// Receiver counts down to each bit middle
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			rx_active <= 1'b0;
			rx_valid <= 1'b0;
			rx_overrun <= 1'b0;
		end else begin
			if (rx_read) begin
				rx_valid <= 1'b0;
				rx_overrun <= 1'b0;
			end
			if (!rx_active) begin
				if (!rx_sync) begin
					rx_active <= 1'b1;
					rx_cnt <= HALF_CNT;
					rx_bit <= '0;
				end
			end else if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt <= LAST_CNT;
				rx_bit <= rx_bit + 4'd1;
				if (rx_bit == 4'd0) begin
					// Line went high again, not a real start bit
					if (rx_sync) begin
						rx_active <= 1'b0;
					end
				end else if (rx_bit != 4'd9) begin
					rx_shift <= {rx_sync, rx_shift[7:1]};
				end else begin
					rx_active <= 1'b0;
					if (rx_sync) begin
						rx_data <= rx_shift;
						rx_valid <= 1'b1;
						rx_overrun <= !rx_read && (rx_valid || rx_overrun);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/host_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_macros.svh"

module host_router (
	input  wire        wb_clk_i,
	input  wire        reset_i,
	input  wire        wbs_stb_i,
	input  wire        wbs_cyc_i,
	input  wire [7:0]  wbs_adr_hi_i,
	input  wire        host_ack_i,
	input  wire [31:0] host_data_i,
	input  wire        caravel_ack_i,
	input  wire [31:0] caravel_data_i,
	output logic       host_stb_o,
	output logic       host_cyc_o,
	output logic       caravel_stb_o,
	output logic       caravel_cyc_o,
	output logic       wbs_ack_o,
	output logic [31:0] wbs_data_o
);

	logic user_space;
	logic host_addr;
	logic host_sel;
	logic caravel_en;

	assign user_space = wbs_adr_hi_i[7:4] == `CH_USER_SPACE;
	assign host_addr = user_space && wbs_adr_hi_i[3:0] == `CH_HOST_PERIPH;

	// Held from the first host strobe until the bridge acks
	always_ff @(posedge wb_clk_i) begin
		if (reset_i || host_ack_i) begin
			host_sel <= 1'b0;
		end else if (wbs_stb_i && wbs_cyc_i && host_addr) begin
			host_sel <= 1'b1;
		end
	end

	// Host addresses never reach the Caravel master, not even before host_sel
	assign caravel_en = user_space && !host_addr && !host_sel;

	assign caravel_stb_o = wbs_stb_i && caravel_en;
	assign caravel_cyc_o = wbs_cyc_i && caravel_en;
	assign host_stb_o = wbs_stb_i && host_sel;
	assign host_cyc_o = wbs_cyc_i && host_sel;

	assign wbs_ack_o = host_sel ? host_ack_i : caravel_ack_i;
	assign wbs_data_o = host_sel ? host_data_i : caravel_data_i;

endmodule

`default_nettype wire

// File: src/caravel_host.sv
`timescale 1ns/1ps
`default_nettype none

module caravel_host (
	input  wire        wb_clk_i,
	input  wire        reset_i,

	// Wishbone slave port from the management core
	input  wire        wbs_stb_i,
	input  wire        wbs_cyc_i,
	input  wire        wbs_we_i,
	input  wire [3:0]  wbs_sel_i,
	input  wire [31:0] wbs_data_i,
	input  wire [31:0] wbs_adr_i,
	output logic       wbs_ack_o,
	output logic [31:0] wbs_data_o,

	// Caravel Wishbone master
	output logic       caravel_wb_cyc_o,
	output logic       caravel_wb_stb_o,
	output logic       caravel_wb_we_o,
	output logic [3:0] caravel_wb_sel_o,
	output logic [31:0] caravel_wb_data_o,
	output logic [27:0] caravel_wb_adr_o,
	input  wire        caravel_wb_ack_i,
	input  wire [31:0] caravel_wb_data_i,

	input  wire        caravel_uart_rx_i,
	output logic       caravel_uart_tx_o
);

	logic        host_stb;
	logic        host_cyc;
	logic        host_ack;
	logic [31:0] host_data;

	periph_bus_if pbus ();

	// Pass-through fields, strobes come from the router
	assign caravel_wb_we_o = wbs_we_i;
	assign caravel_wb_sel_o = wbs_sel_i;
	assign caravel_wb_data_o = wbs_data_i;
	assign caravel_wb_adr_o = wbs_adr_i[27:0];

	host_router router (
		.wb_clk_i       (wb_clk_i),
		.reset_i        (reset_i),
		.wbs_stb_i      (wbs_stb_i),
		.wbs_cyc_i      (wbs_cyc_i),
		.wbs_adr_hi_i   (wbs_adr_i[31:24]),
		.host_ack_i     (host_ack),
		.host_data_i    (host_data),
		.caravel_ack_i  (caravel_wb_ack_i),
		.caravel_data_i (caravel_wb_data_i),
		.host_stb_o     (host_stb),
		.host_cyc_o     (host_cyc),
		.caravel_stb_o  (caravel_wb_stb_o),
		.caravel_cyc_o  (caravel_wb_cyc_o),
		.wbs_ack_o      (wbs_ack_o),
		.wbs_data_o     (wbs_data_o)
	);

	wb_periph_bridge bridge (
		.wb_clk_i  (wb_clk_i),
		.reset_i   (reset_i),
		.wb_stb_i  (host_stb),
		.wb_cyc_i  (host_cyc),
		.wb_we_i   (wbs_we_i),
		.wb_sel_i  (wbs_sel_i),
		.wb_data_i (wbs_data_i),
		.wb_adr_i  (wbs_adr_i[23:0]),
		.wb_ack_o  (host_ack),
		.wb_data_o (host_data),
		.pbus      (pbus.bridge)
	);

	uart_device uart (
		.wb_clk_i  (wb_clk_i),
		.reset_i   (reset_i),
		.uart_rx_i (caravel_uart_rx_i),
		.uart_tx_o (caravel_uart_tx_o),
		.pbus      (pbus.device)
	);

endmodule

`default_nettype wire

// File: tests/caravel_host_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_macros.svh"

module caravel_host_sva (
	input wire        wb_clk_i,
	input wire        reset_i,
	input wire [31:0] wbs_adr_i,
	input wire        wbs_ack_o,
	input wire        caravel_wb_stb_o,
	input wire        caravel_uart_tx_o
);

	int assert_errors = 0;
	logic host_addr;

	assign host_addr = wbs_adr_i[31:28] == `CH_USER_SPACE && wbs_adr_i[27:24] == `CH_HOST_PERIPH;

	// Slave ack is a single-cycle pulse
	ack_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		wbs_ack_o |=> !wbs_ack_o)
	else begin
		$error("wbs_ack_o stayed high for more than one cycle");
		assert_errors++;
	end

	// Host window never reaches the Caravel master
	host_isolated: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		host_addr |-> !caravel_wb_stb_o)
	else begin
		$error("caravel_wb_stb_o high together with a host address");
		assert_errors++;
	end

	reset_idle: assert property (@(posedge wb_clk_i)
		reset_i |=> (caravel_uart_tx_o && !wbs_ack_o))
	else begin
		$error("UART line not idle or ack high right after reset");
		assert_errors++;
	end

endmodule

bind caravel_host caravel_host_sva checks (
	.wb_clk_i          (wb_clk_i),
	.reset_i           (reset_i),
	.wbs_adr_i         (wbs_adr_i),
	.wbs_ack_o         (wbs_ack_o),
	.caravel_wb_stb_o  (caravel_wb_stb_o),
	.caravel_uart_tx_o (caravel_uart_tx_o)
);

`default_nettype wire

// File: tests/caravel_host_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_macros.svh"

module caravel_host_tb;

	localparam int CLK_NS = 40;
	localparam int BIT_NS = `CH_CLKS_PER_BIT * CLK_NS;
	localparam int TX_FRAMES = 3;
	localparam int TIMEOUT_NS = TX_FRAMES * 10 * BIT_NS + 20000;
	localparam logic [15:0] HOST_HI = {`CH_USER_SPACE, `CH_HOST_PERIPH, `CH_UART_ID};
	localparam logic [31:0] TX_ADR = {HOST_HI, `CH_UART_TX_REG};
	localparam logic [31:0] RX_ADR = {HOST_HI, `CH_UART_RX_REG};
	localparam logic [31:0] STATUS_ADR = {HOST_HI, `CH_UART_STATUS_REG};

	logic        wb_clk_i;
	logic        reset_i;
	logic        wbs_stb_i;
	logic        wbs_cyc_i;
	logic        wbs_we_i;
	logic [3:0]  wbs_sel_i;
	logic [31:0] wbs_data_i;
	logic [31:0] wbs_adr_i;
	logic        wbs_ack_o;
	logic [31:0] wbs_data_o;
	logic        caravel_wb_cyc_o;
	logic        caravel_wb_stb_o;
	logic        caravel_wb_we_o;
	logic [3:0]  caravel_wb_sel_o;
	logic [31:0] caravel_wb_data_o;
	logic [27:0] caravel_wb_adr_o;
	logic        caravel_wb_ack_i;
	logic [31:0] caravel_wb_data_i;
	logic        caravel_uart_rx_i;
	logic        caravel_uart_tx_o;

	logic [31:0] model_mem [0:63];
	logic [31:0] shadow_mem [0:63];
	int          model_writes = 0;
	logic [31:0] rng_state = 32'h83b6_9be8;
	logic [7:0]  tx_bytes [$];
	logic [7:0]  frame_bytes [$];
	time         frame_starts [$];
	int          frames_done = 0;
	logic        host_active;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;

	caravel_host uut (.*);

	// UART loopback
	assign caravel_uart_rx_i = caravel_uart_tx_o;

	initial begin
		wb_clk_i = 1'b0;
		forever #(CLK_NS / 2) wb_clk_i = ~wb_clk_i;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] result;
		result = old_word;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				result[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return result;
	endfunction

	// Expected read data for the pass-through window and the UART data registers
	function automatic logic [31:0] expected_read(input logic [31:0] adr);
		if (adr[31:24] == HOST_HI[15:8]) begin
			if (adr[23:0] == RX_ADR[23:0] && tx_bytes.size() > 0) begin
				return {24'h0, tx_bytes[$]};
			end
			return 32'h0;
		end
		return shadow_mem[adr[7:2]];
	endfunction

	function automatic host_pkg::uart_status_t make_status(input logic rx_valid,
			input logic rx_overrun, input logic tx_busy);
		host_pkg::uart_status_t st;
		st.rx_valid = rx_valid;
		st.rx_overrun = rx_overrun;
		st.tx_busy = tx_busy;
		return st;
	endfunction

	function automatic string status_text(input host_pkg::uart_status_t st);
		return $sformatf("rx_valid=%b rx_overrun=%b tx_busy=%b", st.rx_valid, st.rx_overrun,
			st.tx_busy);
	endfunction

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %08h, got %08h", $time, what, exp, got);
		end
	endtask

	task automatic check_status(input string what, input host_pkg::uart_status_t got,
			input host_pkg::uart_status_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %s, got %s", $time, what,
				status_text(exp), status_text(got));
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, what, exp, got);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			$display("Test %0d %s: %0d errors", tests, name, errors - errors_before);
		end
	endtask

	// Classic cycle with the strobe held until ack and latency counted in clocks
	task automatic wb_cycle(input logic write, input logic [31:0] adr, input logic [31:0] wdata,
			input logic [3:0] sel, output logic [31:0] rdata, output int latency);
		@(posedge wb_clk_i);
		#2;
		wbs_adr_i = adr;
		wbs_data_i = wdata;
		wbs_sel_i = sel;
		wbs_we_i = write;
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		latency = 0;
		@(negedge wb_clk_i);
		while (wbs_ack_o !== 1'b1) begin
			latency++;
			@(negedge wb_clk_i);
		end
		rdata = wbs_data_o;
		@(posedge wb_clk_i);
		#2;
		wbs_stb_i = 1'b0;
		wbs_cyc_i = 1'b0;
		wbs_we_i = 1'b0;
	endtask

	task automatic host_cycle(input logic write, input logic [31:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata, output int latency);
		int writes_before;
		writes_before = model_writes;
		host_active = 1'b1;
		wb_cycle(write, adr, wdata, 4'hF, rdata, latency);
		host_active = 1'b0;
		check_word("model writes during host access", model_writes, writes_before);
	endtask

	task automatic read_status(output host_pkg::uart_status_t st, output int latency);
		logic [31:0] rd;
		host_cycle(1'b0, STATUS_ADR, 32'h0, rd, latency);
		st = host_pkg::uart_status_t'(rd[2:0]);
	endtask

	task automatic wait_tx_idle();
		host_pkg::uart_status_t st;
		int lat;
		read_status(st, lat);
		while (st.tx_busy) begin
			read_status(st, lat);
		end
	endtask

	// Caravel slave memory acking one cycle after stb
	initial begin
		caravel_wb_ack_i = 1'b0;
		caravel_wb_data_i = 32'h0;
		for (int i = 0; i < 64; i++) begin
			model_mem[i] = 32'hA5C3_0000 ^ (i * 32'h0101_0101);
			shadow_mem[i] = model_mem[i];
		end
	end

	always @(posedge wb_clk_i) begin
		if (reset_i) begin
			caravel_wb_ack_i <= 1'b0;
		end else if (caravel_wb_ack_i) begin
			caravel_wb_ack_i <= 1'b0;
		end else if (caravel_wb_stb_o && caravel_wb_cyc_o) begin
			caravel_wb_ack_i <= 1'b1;
			caravel_wb_data_i <= model_mem[caravel_wb_adr_o[7:2]];
			if (caravel_wb_we_o) begin
				model_mem[caravel_wb_adr_o[7:2]] <= merge_bytes(model_mem[caravel_wb_adr_o[7:2]],
					caravel_wb_data_o, caravel_wb_sel_o);
				model_writes <= model_writes + 1;
			end
		end
	end

	// Forwarded fields and host isolation on the Caravel master
	always @(negedge wb_clk_i) begin
		if (!reset_i && caravel_wb_stb_o) begin
			check_word("caravel address", {4'h0, caravel_wb_adr_o}, {4'h0, wbs_adr_i[27:0]});
			check_word("caravel write data", caravel_wb_data_o, wbs_data_i);
			check_word("caravel sel", {28'h0, caravel_wb_sel_o}, {28'h0, wbs_sel_i});
			check_bit("caravel we", caravel_wb_we_o, wbs_we_i);
			check_bit("caravel cyc", caravel_wb_cyc_o, 1'b1);
		end
		if (host_active) begin
			check_bit("caravel stb during host access", caravel_wb_stb_o, 1'b0);
			check_bit("caravel cyc during host access", caravel_wb_cyc_o, 1'b0);
		end
	end

	// Frame decoder sampling the TX line at each bit middle
	initial begin
		logic [9:0] bits;
		forever begin
			@(negedge caravel_uart_tx_o);
			if (!reset_i) begin
				frame_starts.push_back($time);
				#(BIT_NS / 2);
				for (int i = 0; i < 10; i++) begin
					bits[i] = caravel_uart_tx_o;
					if (i < 9) begin
						#(BIT_NS);
					end
				end
				check_bit("start bit", bits[0], 1'b0);
				check_bit("stop bit", bits[9], 1'b1);
				frame_bytes.push_back(bits[8:1]);
				frames_done++;
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] adr;
		logic [31:0] data;
		logic [31:0] rd;
		logic [3:0] sel;
		logic [7:0] b;
		int lat;
		int err_start;
		int first_frame;
		host_pkg::uart_status_t st;

		reset_i = 1'b1;
		wbs_stb_i = 1'b0;
		wbs_cyc_i = 1'b0;
		wbs_we_i = 1'b0;
		wbs_sel_i = 4'h0;
		wbs_data_i = 32'h0;
		wbs_adr_i = 32'h0;
		host_active = 1'b0;
		repeat (5) @(posedge wb_clk_i);
		#2;
		reset_i = 1'b0;

		err_start = errors;
		@(negedge wb_clk_i);
		check_bit("wbs_ack_o after reset", wbs_ack_o, 1'b0);
		check_bit("caravel stb after reset", caravel_wb_stb_o, 1'b0);
		check_bit("caravel cyc after reset", caravel_wb_cyc_o, 1'b0);
		check_bit("uart tx after reset", caravel_uart_tx_o, 1'b1);
		report_test("reset state", err_start);

		err_start = errors;
		for (int n = 0; n < 16; n++) begin
			next_random(r);
			adr = {`CH_USER_SPACE, 1'b0, r[26:2], 2'b00};
			next_random(data);
			sel = (r[31:28] == 4'h0) ? 4'hF : r[31:28];
			if (r[27]) begin
				wb_cycle(1'b1, adr, data, sel, rd, lat);
				shadow_mem[adr[7:2]] = merge_bytes(shadow_mem[adr[7:2]], data, sel);
			end else begin
				wb_cycle(1'b0, adr, 32'h0, 4'hF, rd, lat);
				check_word("pass-through read", rd, expected_read(adr));
			end
		end
		report_test("pass-through", err_start);

		err_start = errors;
		read_status(st, lat);
		check_word("status read latency", lat, 2);
		check_status("idle status", st, make_status(1'b0, 1'b0, 1'b0));
		host_cycle(1'b0, {HOST_HI, 16'h000C}, 32'h0, rd, lat);
		check_word("unmapped UART offset", rd, expected_read({HOST_HI, 16'h000C}));
		host_cycle(1'b1, {HOST_HI[15:8], 8'h02, 16'h0000}, 32'h55, rd, lat);
		check_word("other peripheral ID latency", lat, 2);
		for (int i = 0; i < 64; i++) begin
			check_word("model memory word", model_mem[i], shadow_mem[i]);
		end
		report_test("host isolation", err_start);

		err_start = errors;
		next_random(r);
		b = r[7:0];
		host_cycle(1'b1, TX_ADR, {24'h0, b}, rd, lat);
		tx_bytes.push_back(b);
		check_word("TX write latency", lat, 2);
		wait (frames_done >= 1);
		check_word("TX frame byte", {24'h0, frame_bytes[0]}, {24'h0, b});
		report_test("TX frame", err_start);

		err_start = errors;
		wait_tx_idle();
		read_status(st, lat);
		check_status("status after frame", st, make_status(1'b1, 1'b0, 1'b0));
		host_cycle(1'b0, RX_ADR, 32'h0, rd, lat);
		check_word("RX byte", rd, expected_read(RX_ADR));
		read_status(st, lat);
		check_status("status after RX read", st, make_status(1'b0, 1'b0, 1'b0));
		report_test("loopback receive", err_start);

		err_start = errors;
		first_frame = frames_done;
		next_random(r);
		host_cycle(1'b1, TX_ADR, {24'h0, r[7:0]}, rd, lat);
		tx_bytes.push_back(r[7:0]);
		check_word("first TX write latency", lat, 2);
		host_cycle(1'b1, TX_ADR, {24'h0, r[15:8]}, rd, lat);
		tx_bytes.push_back(r[15:8]);
		check_bit("second TX ack after first frame",
			$time >= frame_starts[first_frame] + 10 * BIT_NS, 1'b1);
		wait (frames_done >= first_frame + 2);
		wait_tx_idle();
		check_word("first frame byte", {24'h0, frame_bytes[first_frame]}, {24'h0, r[7:0]});
		check_word("second frame byte", {24'h0, frame_bytes[first_frame + 1]}, {24'h0, r[15:8]});
		read_status(st, lat);
		check_status("status after overrun", st, make_status(1'b1, 1'b1, 1'b0));
		host_cycle(1'b0, RX_ADR, 32'h0, rd, lat);
		check_word("RX holds second byte", rd, expected_read(RX_ADR));
		read_status(st, lat);
		check_status("status after RX read", st, make_status(1'b0, 1'b0, 1'b0));
		check_word("frames on the line", frames_done, tx_bytes.size());
		report_test("back-pressure and overrun", err_start);

		$display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
			tests, checks, errors, uut.checks.assert_errors);
		if (errors == 0 && uut.checks.assert_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
src/host_pkg.sv
src/periph_bus_if.sv
src/wb_periph_bridge.sv
src/uart_device.sv
src/host_router.sv
src/caravel_host.sv
tests/caravel_host_sva.sv
tests/caravel_host_tb.sv
